// ==== src/game_pkg.sv ====
package game_pkg;

  // screen position, covers an 800x600 raster with its blanking
  typedef logic [10:0] coord_t;

  // 4 bits each of red, green, blue
  typedef logic [11:0] rgb_t;

  localparam coord_t SCREEN_W = 11'd800;  // visible width, ship is kept inside

  // ship is a solid rectangle on a fixed row
  localparam coord_t SHIP_Y   = 11'd560;
  localparam coord_t SHIP_W   = 11'd32;
  localparam coord_t SHIP_H   = 11'd16;
  localparam rgb_t   SHIP_RGB = 12'h0_c_4;

  // thin vertical bar
  localparam coord_t MISSILE_W   = 11'd2;
  localparam coord_t MISSILE_H   = 11'd8;
  localparam rgb_t   MISSILE_RGB = 12'hf_e_0;

endpackage

// ==== src/ship_pos_ctl.sv ====
`timescale 1ns/10ps

module ship_pos_ctl #(
  parameter int SHIP_STEP = 4
) (
  input  logic             pclk,
  input  logic             reset_i,
  input  logic             left_i,
  input  logic             right_i,
  input  logic             vblnk_i,
  output logic             frame_tick_o,
  output game_pkg::coord_t ship_x_o
);

  localparam game_pkg::coord_t STEP  = game_pkg::coord_t'(SHIP_STEP);
  localparam game_pkg::coord_t X_MAX = game_pkg::SCREEN_W - game_pkg::SHIP_W;
  localparam game_pkg::coord_t X_MID = X_MAX / 2;

  logic             vblnk_q;
  logic             frame_start;
  game_pkg::coord_t x_next;

  assign frame_start = vblnk_i && !vblnk_q;  // first blank cycle of a frame

  // saturating move, opposing buttons cancel
  always_comb begin
    x_next = ship_x_o;
    if (right_i && !left_i) begin
      if (ship_x_o > X_MAX - STEP) begin
        x_next = X_MAX;
      end else begin
        x_next = ship_x_o + STEP;
      end
    end else if (left_i && !right_i) begin
      if (ship_x_o < STEP) begin
        x_next = '0;
      end else begin
        x_next = ship_x_o - STEP;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      vblnk_q      <= 1'b0;
      frame_tick_o <= 1'b0;
      ship_x_o     <= X_MID;  // start centred
    end else begin
      vblnk_q      <= vblnk_i;
      frame_tick_o <= frame_start;
      if (frame_start) begin
        ship_x_o <= x_next;  // lands together with the tick
      end
    end
  end

endmodule

// ==== src/missile_launcher.sv ====
`timescale 1ns/10ps

module missile_launcher #(
  parameter int N_MISSILES = 4
) (
  input  logic                  pclk,
  input  logic                  reset_i,
  input  logic                  fire_i,
  input  game_pkg::coord_t      ship_x_i,
  input  logic [N_MISSILES-1:0] slot_busy_i,
  output logic [N_MISSILES-1:0] launch_o,
  output game_pkg::coord_t      launch_x_o
);

  // offset from ship left edge to the missile's left edge
  localparam game_pkg::coord_t CENTRE_OFS =
    game_pkg::SHIP_W / 2 - game_pkg::MISSILE_W / 2;

  logic                  fire_q;
  logic                  fire_edge;
  logic [N_MISSILES-1:0] free_mask;
  logic [N_MISSILES-1:0] pick;

  assign fire_edge = fire_i && !fire_q;
  assign free_mask = ~slot_busy_i;

  // isolate the lowest free slot, zero when all are taken
  assign pick = free_mask & (~free_mask + N_MISSILES'(1));

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      fire_q   <= 1'b0;
      launch_o <= '0;
    end else begin
      fire_q   <= fire_i;
      launch_o <= {N_MISSILES{fire_edge}} & pick;  // one cycle pulse
    end
  end

  // start position sampled at the press
  always_ff @(posedge pclk) begin
    if (fire_edge) begin
      launch_x_o <= ship_x_i + CENTRE_OFS;
    end
  end

endmodule

// ==== src/missile_slot.sv ====
`timescale 1ns/10ps

module missile_slot #(
  parameter int MISSILE_STEP = 8
) (
  input  logic             pclk,
  input  logic             reset_i,
  input  logic             launch_i,
  input  game_pkg::coord_t launch_x_i,
  input  logic             frame_tick_i,
  output logic             busy_o,
  output game_pkg::coord_t x_o,
  output game_pkg::coord_t y_o
);

  typedef enum logic {
    IDLE,
    FLYING
  } state_t;

  localparam game_pkg::coord_t STEP    = game_pkg::coord_t'(MISSILE_STEP);
  localparam game_pkg::coord_t START_Y = game_pkg::SHIP_Y - game_pkg::MISSILE_H;

  state_t state;
  logic   at_top;

  assign at_top = y_o < STEP;  // next climb would leave the screen
  assign busy_o = (state == FLYING);

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (launch_i) state <= FLYING;
        FLYING:  if (frame_tick_i && at_top) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // position, only meaningful while flying
  always_ff @(posedge pclk) begin
    if (state == IDLE && launch_i) begin
      x_o <= launch_x_i;
      y_o <= START_Y;  // just above the ship
    end else if (state == FLYING && frame_tick_i && !at_top) begin
      y_o <= y_o - STEP;
    end
  end

endmodule

// ==== src/sprite_overlay.sv ====
`timescale 1ns/10ps

module sprite_overlay #(
  parameter int N_MISSILES = 4
) (
  input  logic                                            pclk,
  input  logic                                            reset_i,
  input  game_pkg::coord_t                                hcount_i,
  input  game_pkg::coord_t                                vcount_i,
  input  logic                                            hsync_i,
  input  logic                                            vsync_i,
  input  logic                                            hblnk_i,
  input  logic                                            vblnk_i,
  input  game_pkg::rgb_t                                  rgb_i,
  input  game_pkg::coord_t                                ship_x_i,
  input  logic [N_MISSILES-1:0]                           slot_busy_i,
  input  logic [N_MISSILES*$bits(game_pkg::coord_t)-1:0] missile_x_i,
  input  logic [N_MISSILES*$bits(game_pkg::coord_t)-1:0] missile_y_i,
  output game_pkg::coord_t                                hcount_o,
  output game_pkg::coord_t                                vcount_o,
  output logic                                            hsync_o,
  output logic                                            vsync_o,
  output logic                                            hblnk_o,
  output logic                                            vblnk_o,
  output game_pkg::rgb_t                                  rgb_o
);

  localparam int CW = $bits(game_pkg::coord_t);

  logic [N_MISSILES-1:0] slot_hit;
  logic                  ship_hit;
  game_pkg::rgb_t        rgb_next;

  // stage 1
  game_pkg::coord_t hcount_q;
  game_pkg::coord_t vcount_q;
  logic             hsync_q;
  logic             vsync_q;
  logic             hblnk_q;
  logic             vblnk_q;
  game_pkg::rgb_t   rgb_q;
  logic             ship_hit_q;
  logic             missile_hit_q;

  assign ship_hit = (hcount_i >= ship_x_i)
                 && (hcount_i <  ship_x_i + game_pkg::SHIP_W)
                 && (vcount_i >= game_pkg::SHIP_Y)
                 && (vcount_i <  game_pkg::SHIP_Y + game_pkg::SHIP_H);

  // one rectangle test per slot, idle slots never hit
  for (genvar k = 0; k < N_MISSILES; k++) begin : g_hit
    game_pkg::coord_t mx;
    game_pkg::coord_t my;
    assign mx = missile_x_i[k*CW +: CW];
    assign my = missile_y_i[k*CW +: CW];
    assign slot_hit[k] = slot_busy_i[k]
                      && (hcount_i >= mx) && (hcount_i < mx + game_pkg::MISSILE_W)
                      && (vcount_i >= my) && (vcount_i < my + game_pkg::MISSILE_H);
  end

  always_ff @(posedge pclk) begin
    if (reset_i) begin
      {hsync_q, vsync_q, hblnk_q, vblnk_q} <= '0;
      {hsync_o, vsync_o, hblnk_o, vblnk_o} <= '0;
      rgb_o                                <= '0;
    end else begin
      {hsync_q, vsync_q, hblnk_q, vblnk_q} <= {hsync_i, vsync_i, hblnk_i, vblnk_i};
      {hsync_o, vsync_o, hblnk_o, vblnk_o} <= {hsync_q, vsync_q, hblnk_q, vblnk_q};
      rgb_o                                <= rgb_next;
    end
  end

  always_ff @(posedge pclk) begin
    hcount_q      <= hcount_i;
    vcount_q      <= vcount_i;
    rgb_q         <= rgb_i;
    ship_hit_q    <= ship_hit;
    missile_hit_q <= |slot_hit;
    hcount_o      <= hcount_q;  // stage 2
    vcount_o      <= vcount_q;
  end

  // missiles sit on top of the ship
  always_comb begin
    rgb_next = rgb_q;
    if (!hblnk_q && !vblnk_q) begin
      if (missile_hit_q) begin
        rgb_next = game_pkg::MISSILE_RGB;
      end else if (ship_hit_q) begin
        rgb_next = game_pkg::SHIP_RGB;
      end
    end
  end

endmodule

// ==== src/draw_ship.sv ====
`timescale 1ns/10ps

module draw_ship #(
  parameter int N_MISSILES   = 4,
  parameter int SHIP_STEP    = 4,
  parameter int MISSILE_STEP = 8
) (
  input  logic             pclk,
  input  logic             reset_i,
  input  logic             left_i,
  input  logic             right_i,
  input  logic             fire_i,
  input  game_pkg::coord_t hcount_i,
  input  game_pkg::coord_t vcount_i,
  input  logic             hsync_i,
  input  logic             vsync_i,
  input  logic             hblnk_i,
  input  logic             vblnk_i,
  input  game_pkg::rgb_t   rgb_i,
  output game_pkg::coord_t hcount_o,
  output game_pkg::coord_t vcount_o,
  output logic             hsync_o,
  output logic             vsync_o,
  output logic             hblnk_o,
  output logic             vblnk_o,
  output game_pkg::rgb_t   rgb_o
);

  localparam int CW = $bits(game_pkg::coord_t);

  logic                     frame_tick;
  game_pkg::coord_t         ship_x;
  game_pkg::coord_t         launch_x;
  logic [N_MISSILES-1:0]    launch;
  logic [N_MISSILES-1:0]    slot_busy;
  logic [N_MISSILES*CW-1:0] missile_x;  // slot k at bits k*CW
  logic [N_MISSILES*CW-1:0] missile_y;

  ship_pos_ctl #(
    .SHIP_STEP(SHIP_STEP)
  ) i_ship_pos_ctl (
    .pclk        (pclk),
    .reset_i     (reset_i),
    .left_i      (left_i),
    .right_i     (right_i),
    .vblnk_i     (vblnk_i),
    .frame_tick_o(frame_tick),
    .ship_x_o    (ship_x)
  );

  missile_launcher #(
    .N_MISSILES(N_MISSILES)
  ) i_missile_launcher (
    .pclk       (pclk),
    .reset_i    (reset_i),
    .fire_i     (fire_i),
    .ship_x_i   (ship_x),
    .slot_busy_i(slot_busy),
    .launch_o   (launch),
    .launch_x_o (launch_x)
  );

  for (genvar k = 0; k < N_MISSILES; k++) begin : g_slot
    missile_slot #(
      .MISSILE_STEP(MISSILE_STEP)
    ) i_missile_slot (
      .pclk        (pclk),
      .reset_i     (reset_i),
      .launch_i    (launch[k]),
      .launch_x_i  (launch_x),
      .frame_tick_i(frame_tick),
      .busy_o      (slot_busy[k]),
      .x_o         (missile_x[k*CW +: CW]),
      .y_o         (missile_y[k*CW +: CW])
    );
  end

  sprite_overlay #(
    .N_MISSILES(N_MISSILES)
  ) i_sprite_overlay (
    .pclk       (pclk),
    .reset_i    (reset_i),
    .hcount_i   (hcount_i),
    .vcount_i   (vcount_i),
    .hsync_i    (hsync_i),
    .vsync_i    (vsync_i),
    .hblnk_i    (hblnk_i),
    .vblnk_i    (vblnk_i),
    .rgb_i      (rgb_i),
    .ship_x_i   (ship_x),
    .slot_busy_i(slot_busy),
    .missile_x_i(missile_x),
    .missile_y_i(missile_y),
    .hcount_o   (hcount_o),
    .vcount_o   (vcount_o),
    .hsync_o    (hsync_o),
    .vsync_o    (vsync_o),
    .hblnk_o    (hblnk_o),
    .vblnk_o    (vblnk_o),
    .rgb_o      (rgb_o)
  );

endmodule

// ==== tb/draw_ship_properties.sv ====
`timescale 1ns/10ps

module draw_ship_properties #(
  parameter int N = 4
) (
  input logic         pclk,
  input logic         reset_i,
  input logic [N-1:0] launch,
  input logic [N-1:0] busy,
  input logic         frame_tick
);

  a_launch_onehot: assert property (@(posedge pclk) disable iff (reset_i)
    $onehot0(launch)) else $error("launch vector is not one-hot or zero");

  a_launch_free: assert property (@(posedge pclk) disable iff (reset_i)
    (launch & busy) == '0) else $error("launch targets a busy slot");

  // slots retire only on a frame tick
  a_busy_fall: assert property (@(posedge pclk) disable iff (reset_i)
    (busy != '1 && $past(busy) == '1 && N == 1) |-> $past(frame_tick))
    else $error("busy fell without a frame tick");

endmodule

bind missile_launcher draw_ship_properties #(.N(N_MISSILES)) i_launcher_props (
  .pclk(pclk), .reset_i(reset_i), .launch(launch_o), .busy(slot_busy_i), .frame_tick(1'b1)
);

bind missile_slot draw_ship_properties #(.N(1)) i_slot_props (
  .pclk(pclk), .reset_i(reset_i), .launch(launch_i), .busy(busy_o),
  .frame_tick(frame_tick_i)
);

// ==== tb/tb_draw_ship.sv ====
`timescale 1ns/10ps

module tb_draw_ship;

  localparam int N_MISSILES = 4, SHIP_STEP = 4, MISSILE_STEP = 8;
  localparam int H_TOTAL = 72, H_VIS = 64, V_TOTAL = 24, V_VIS = 20;  // tiny raster
  localparam int N_FRAMES = 450, TIMEOUT = 1_000_000;
  localparam int X_MAX = game_pkg::SCREEN_W - game_pkg::SHIP_W;

  logic pclk = 1'b0, reset_i, left_i, right_i, fire_i;
  logic hsync_i, vsync_i, hblnk_i, vblnk_i, hsync_o, vsync_o, hblnk_o, vblnk_o;
  game_pkg::coord_t hcount_i, vcount_i, hcount_o, vcount_o, hbase, vbase;
  game_pkg::rgb_t   rgb_i, rgb_o;

  // reference model state
  logic m_vblnk_q, m_tick, m_fire_q, s1_hs, s1_vs, s1_hb, s1_vb, s1_shit, s1_mhit;
  logic e_hs, e_vs, e_hb, e_vb;
  logic [N_MISSILES-1:0] m_launch, m_busy;
  game_pkg::coord_t m_ship_x, m_launch_x, s1_h, s1_v, e_h, e_v;
  game_pkg::coord_t m_mx [N_MISSILES];
  game_pkg::coord_t m_my [N_MISSILES];
  game_pkg::rgb_t   s1_rgb, e_rgb;
  int h = 0, v = 0, frame_cnt = 0, cycles = 0;
  int n_left = 0, n_right = 0, n_drop = 0, n_missile_px = 0, n_ship_px = 0;

  draw_ship #(.N_MISSILES(N_MISSILES), .SHIP_STEP(SHIP_STEP), .MISSILE_STEP(MISSILE_STEP))
    i_draw_ship (.*);

  always #50 pclk = ~pclk;

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic compare_rgb(input string name, input game_pkg::rgb_t got, exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
      fail_with("rgb mismatch");
    end
  endtask

  task automatic compare_coord(input string name, input game_pkg::coord_t got, exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp);
      fail_with("coordinate mismatch");
    end
  endtask

  task automatic compare_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
      fail_with("timing signal mismatch");
    end
  endtask

  // reference model for one clock with the inputs seen at this edge
  task automatic step_model();
    logic fs, fire_edge, shit, mhit;
    logic [N_MISSILES-1:0] pick;
    int nx;
    fs = vblnk_i && !m_vblnk_q;
    fire_edge = fire_i && !m_fire_q;
    pick = '0;
    for (int k = N_MISSILES - 1; k >= 0; k--) begin
      if (!m_busy[k]) pick = N_MISSILES'(1) << k;  // lowest free wins
    end
    shit = int'(hcount_i) >= int'(m_ship_x) && int'(hcount_i) < m_ship_x + 32
        && vcount_i >= game_pkg::SHIP_Y && vcount_i < game_pkg::SHIP_Y + game_pkg::SHIP_H;
    mhit = 1'b0;
    for (int k = 0; k < N_MISSILES; k++) begin
      if (m_busy[k] && hcount_i >= m_mx[k] && hcount_i < m_mx[k] + game_pkg::MISSILE_W
          && vcount_i >= m_my[k] && vcount_i < m_my[k] + game_pkg::MISSILE_H) mhit = 1'b1;
    end
    e_h = s1_h;  // stage 2
    e_v = s1_v;
    {e_hs, e_vs, e_hb, e_vb} = reset_i ? 4'b0 : {s1_hs, s1_vs, s1_hb, s1_vb};
    e_rgb = s1_rgb;
    if (!s1_hb && !s1_vb) begin
      e_rgb = s1_mhit ? game_pkg::MISSILE_RGB : s1_shit ? game_pkg::SHIP_RGB : s1_rgb;
    end
    if (reset_i) e_rgb = '0;
    if (!reset_i && !s1_hb && !s1_vb && s1_mhit) n_missile_px++;
    if (!reset_i && !s1_hb && !s1_vb && s1_shit && !s1_mhit) n_ship_px++;
    {s1_h, s1_v, s1_rgb, s1_shit, s1_mhit} = {hcount_i, vcount_i, rgb_i, shit, mhit};
    {s1_hs, s1_vs, s1_hb, s1_vb} = reset_i ? 4'b0 : {hsync_i, vsync_i, hblnk_i, vblnk_i};
    for (int k = 0; k < N_MISSILES; k++) begin
      if (reset_i) m_busy[k] = 1'b0;
      else if (!m_busy[k] && m_launch[k]) begin
        m_busy[k] = 1'b1;
        m_mx[k] = m_launch_x;
        m_my[k] = game_pkg::SHIP_Y - game_pkg::MISSILE_H;
      end else if (m_busy[k] && m_tick) begin
        if (m_my[k] < MISSILE_STEP) m_busy[k] = 1'b0;  // retires at the top
        else m_my[k] = m_my[k] - MISSILE_STEP;
      end
    end
    if (fire_edge) m_launch_x = m_ship_x + game_pkg::SHIP_W / 2 - game_pkg::MISSILE_W / 2;
    if (!reset_i && fire_edge && pick == '0) n_drop++;
    m_launch = (reset_i || !fire_edge) ? '0 : pick;
    m_fire_q = reset_i ? 1'b0 : fire_i;
    m_tick = reset_i ? 1'b0 : fs;
    m_vblnk_q = reset_i ? 1'b0 : vblnk_i;
    nx = m_ship_x;
    if (right_i && !left_i) nx = (nx + SHIP_STEP > X_MAX) ? X_MAX : nx + SHIP_STEP;
    if (left_i && !right_i) nx = (nx - SHIP_STEP < 0) ? 0 : nx - SHIP_STEP;
    if (reset_i) m_ship_x = X_MAX / 2;
    else if (fs) m_ship_x = nx;
    if (m_ship_x == 0) n_left++;
    if (m_ship_x == X_MAX) n_right++;
  endtask

  // raster window follows the ship, odd frames look at a flying missile
  task automatic drive_raster();
    int b;
    if (h == 0 && v == 0) begin
      frame_cnt++;
      b = -1;
      for (int k = N_MISSILES - 1; k >= 0; k--) if (m_busy[k]) b = k;
      hbase = m_ship_x >= 16 ? m_ship_x - 16 : 0;
      vbase = game_pkg::SHIP_Y - 12;
      if (frame_cnt[0] && b >= 0) begin
        hbase = m_mx[b] >= 20 ? m_mx[b] - 20 : 0;
        vbase = m_my[b] >= 4 ? m_my[b] - 4 : 0;
      end
    end
    hcount_i <= hbase + h;
    vcount_i <= vbase + v;
    hblnk_i  <= h >= H_VIS;
    vblnk_i  <= v >= V_VIS;
    hsync_i  <= h >= 66 && h < 70;
    vsync_i  <= v >= 21 && v < 23;
    rgb_i    <= game_pkg::rgb_t'($urandom);
    if (frame_cnt < 150) begin
      right_i <= $urandom % 16 != 0;
      left_i  <= $urandom % 16 == 0;
    end else begin
      right_i <= $urandom % 16 == 0;
      left_i  <= $urandom % 16 != 0;
    end
    if ($urandom % 256 == 0) fire_i <= !fire_i;
    h = (h == H_TOTAL - 1) ? 0 : h + 1;
    if (h == 0) v = (v == V_TOTAL - 1) ? 0 : v + 1;
  endtask

  always @(posedge pclk) begin
    step_model();
    drive_raster();
    cycles++;
  end

  always @(negedge pclk) begin
    if (cycles > 0) begin
      compare_bit("hsync_o", hsync_o, e_hs);
      compare_bit("vsync_o", vsync_o, e_vs);
      compare_bit("hblnk_o", hblnk_o, e_hb);
      compare_bit("vblnk_o", vblnk_o, e_vb);
      compare_rgb("rgb_o", rgb_o, e_rgb);
    end
    if (cycles > 2) begin
      compare_coord("hcount_o", hcount_o, e_h);
      compare_coord("vcount_o", vcount_o, e_v);
    end
  end

  initial begin
    int seed;
    int cyc;
    string missing;
    seed = $urandom(27250);
    {reset_i, left_i, right_i, fire_i} = 4'b1000;
    {hsync_i, vsync_i, hblnk_i, vblnk_i} = 4'b0;
    hcount_i = '0;
    vcount_i = '0;
    rgb_i = '0;
    for (cyc = 0; cyc < 2; cyc++) @(posedge pclk);
    reset_i <= 1'b0;
    cyc = 0;
    while (frame_cnt < N_FRAMES && cyc < TIMEOUT) begin
      @(posedge pclk);
      cyc++;
    end
    if (cyc >= TIMEOUT) fail_with("timeout, raster did not reach the last frame");
    missing = "";
    if (n_left == 0 || n_right == 0) missing = "ship never reached both screen limits";
    if (n_missile_px == 0 || n_ship_px == 0) missing = "ship or missile was never painted";
    if (n_drop == 0) missing = "no press was dropped with every slot busy";
    if (missing != "") begin
      fail_with(missing);
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
src/game_pkg.sv
src/ship_pos_ctl.sv
src/missile_launcher.sv
src/missile_slot.sv
src/sprite_overlay.sv
src/draw_ship.sv
tb/draw_ship_properties.sv
tb/tb_draw_ship.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_draw_ship
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
